// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Fetch address taken on reset.
`define INIT_ADDR 32'h0000_0000

// Encoding of andi r0, r0, 0 used as the no-op word.
`define INST_NOP 32'h0340_0000

`endif

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] addr_t;  // Byte address of an instruction.
    typedef logic [31:0] inst_t;  // One instruction word.

    // Bit 0 enables inst0 and bit 1 enables inst1.
    typedef logic [1:0] issue_t;

    localparam issue_t ISSUE_BOTH = 2'b11;
    localparam issue_t ISSUE_INST1 = 2'b10;  // Fetch entered on the odd word of a pair.

    // A pair covers two words, so the next pair lies eight bytes on.
    localparam int PAIR_BYTES = 8;

    // Width of one packed pair record of pc, npc, branch flag, inst0, inst1 and issue.
    localparam int PAIR_W = 2 * $bits(addr_t) + 1 + 2 * $bits(inst_t) + $bits(issue_t);

    typedef enum logic {
        RUN,
        REDIRECTED
    } pc_state_t;

endpackage

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module pc_gen (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              flush_i,
    input  fetch_pkg::addr_t  redirect_pc_i,
    output logic              req_valid_o,
    input  logic              req_ready_i,
    output fetch_pkg::addr_t  req_pc_o,
    output fetch_pkg::addr_t  req_npc_o,
    output logic              req_branch_flag_o,
    output fetch_pkg::issue_t req_issue_o
);
    import fetch_pkg::*;

    addr_t     pc_q;
    addr_t     pair_base;
    logic      valid_q;
    logic      accept;
    pc_state_t state_q;

    assign pair_base = {pc_q[31:3], 3'b000};
    assign accept    = valid_q && req_ready_i;

    assign req_valid_o       = valid_q;
    assign req_pc_o          = pc_q;
    assign req_npc_o         = pair_base + addr_t'(PAIR_BYTES);
    assign req_branch_flag_o = (state_q == REDIRECTED);  // Only the first pair after a redirect.

    // An odd-word entry point leaves only inst1 to issue.
    assign req_issue_o = pc_q[2] ? ISSUE_INST1 : ISSUE_BOTH;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
            pc_q    <= `INIT_ADDR;
            state_q <= RUN;
        end else if (flush_i) begin
            // The redirect target is offered from the very next cycle.
            valid_q <= 1'b1;
            pc_q    <= redirect_pc_i;
            state_q <= REDIRECTED;
        end else begin
            valid_q <= 1'b1;
            if (accept) begin
                pc_q    <= req_npc_o;  // Step to the following aligned pair.
                state_q <= RUN;
            end
        end
    end

endmodule

// ==== hdl/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
    parameter int IMEM_PAIRS = 64
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        flush_i,

    input  logic                        we_i,
    input  logic [$clog2(IMEM_PAIRS):0] waddr_i,  // Word index.
    input  fetch_pkg::inst_t            wdata_i,

    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  fetch_pkg::addr_t            req_pc_i,
    input  fetch_pkg::addr_t            req_npc_i,
    input  logic                        req_branch_flag_i,
    input  fetch_pkg::issue_t           req_issue_i,

    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    output fetch_pkg::addr_t            rsp_pc_o,
    output fetch_pkg::addr_t            rsp_npc_o,
    output logic                        rsp_branch_flag_o,
    output fetch_pkg::issue_t           rsp_issue_o,
    output fetch_pkg::inst_t            rsp_inst0_o,
    output fetch_pkg::inst_t            rsp_inst1_o
);
    import fetch_pkg::*;

    localparam int PAIR_AW = $clog2(IMEM_PAIRS);

    inst_t              mem [2 * IMEM_PAIRS];
    logic [PAIR_AW-1:0] rd_pair;
    logic               accept;

    // Pair index taken from the address, so fetch wraps around the array.
    assign rd_pair = req_pc_i[PAIR_AW+2:3];

    // The output slot is free when it is empty or drained on this edge.
    assign req_ready_o = !rsp_valid_o || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge aclk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rsp_valid_o <= 1'b0;
        end else if (flush_i) begin
            rsp_valid_o <= 1'b0;  // Anything in flight belongs to the old path.
        end else if (req_ready_o) begin
            rsp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            rsp_pc_o          <= req_pc_i;
            rsp_npc_o         <= req_npc_i;
            rsp_branch_flag_o <= req_branch_flag_i;
            rsp_issue_o       <= req_issue_i;
            rsp_inst0_o       <= mem[{rd_pair, 1'b0}];
            rsp_inst1_o       <= mem[{rd_pair, 1'b1}];
        end
    end

endmodule

// ==== hdl/if1_stage_reg.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module if1_stage_reg (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              flush_i,

    input  logic              rsp_valid_i,
    output logic              rsp_ready_o,
    input  fetch_pkg::addr_t  rsp_pc_i,
    input  fetch_pkg::addr_t  rsp_npc_i,
    input  logic              rsp_branch_flag_i,
    input  fetch_pkg::issue_t rsp_issue_i,
    input  fetch_pkg::inst_t  rsp_inst0_i,
    input  fetch_pkg::inst_t  rsp_inst1_i,

    output logic              s_valid_o,
    input  logic              s_ready_i,
    output fetch_pkg::addr_t  pc_o,
    output fetch_pkg::addr_t  npc_o,
    output logic              branch_flag_o,
    output fetch_pkg::inst_t  inst0_o,
    output fetch_pkg::inst_t  inst1_o,
    output fetch_pkg::issue_t issue_o
);
    import fetch_pkg::*;

    logic accept;

    assign rsp_ready_o = !s_valid_o || s_ready_i;
    assign accept      = rsp_valid_i && rsp_ready_o;

    always_ff @(posedge aclk) begin
        if (!aresetn || flush_i) begin
            // Park a harmless no-op pair at the reset address.
            s_valid_o     <= 1'b0;
            pc_o          <= `INIT_ADDR;
            npc_o         <= `INIT_ADDR;
            branch_flag_o <= 1'b0;
            inst0_o       <= `INST_NOP;
            inst1_o       <= `INST_NOP;
            issue_o       <= ISSUE_BOTH;
        end else begin
            if (rsp_ready_o) begin
                s_valid_o <= rsp_valid_i;
            end
            if (accept) begin
                pc_o          <= rsp_pc_i;
                npc_o         <= rsp_npc_i;
                branch_flag_o <= rsp_branch_flag_i;
                inst0_o       <= rsp_inst0_i;
                inst1_o       <= rsp_inst1_i;
                issue_o       <= rsp_issue_i;
            end
        end
    end

endmodule

// ==== hdl/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              flush_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  fetch_pkg::addr_t  in_pc_i,
    input  fetch_pkg::addr_t  in_npc_i,
    input  logic              in_branch_flag_i,
    input  fetch_pkg::inst_t  in_inst0_i,
    input  fetch_pkg::inst_t  in_inst1_i,
    input  fetch_pkg::issue_t in_issue_i,

    output logic              out_valid_o,
    input  logic              out_ready_i,
    output fetch_pkg::addr_t  out_pc_o,
    output fetch_pkg::addr_t  out_npc_o,
    output logic              out_branch_flag_o,
    output fetch_pkg::inst_t  out_inst0_o,
    output fetch_pkg::inst_t  out_inst1_o,
    output fetch_pkg::issue_t out_issue_o
);
    import fetch_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [PAIR_W-1:0] entries [FIFO_DEPTH];
    logic [PAIR_W-1:0] wr_entry;
    logic [PAIR_W-1:0] rd_entry;
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              full;
    logic              push;
    logic              pop;

    // Pointers wrap at the depth, which need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full        = (count_q == CNT_W'(FIFO_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign pop         = out_valid_o && out_ready_i;

    // A full buffer still takes a pair when the head leaves on the same edge.
    assign in_ready_o = !full || out_ready_i;
    assign push       = in_valid_i && in_ready_o;

    assign wr_entry = {in_pc_i, in_npc_i, in_branch_flag_i,
                       in_inst0_i, in_inst1_i, in_issue_i};
    assign rd_entry = entries[rd_ptr_q];

    assign {out_pc_o, out_npc_o, out_branch_flag_o,
            out_inst0_o, out_inst1_o, out_issue_o} = rd_entry;

    always_ff @(posedge aclk) begin
        if (push) begin
            entries[wr_ptr_q] <= wr_entry;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;  // Old pairs are dropped by emptying the queue.
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int IMEM_PAIRS = 64,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        aclk,
    input  logic                        aresetn,

    input  logic                        redirect_valid_i,
    input  fetch_pkg::addr_t            redirect_pc_i,

    input  logic                        imem_we_i,
    input  logic [$clog2(IMEM_PAIRS):0] imem_waddr_i,
    input  fetch_pkg::inst_t            imem_wdata_i,

    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output fetch_pkg::addr_t            out_pc_o,
    output fetch_pkg::addr_t            out_npc_o,
    output logic                        out_branch_flag_o,
    output fetch_pkg::inst_t            out_inst0_o,
    output fetch_pkg::inst_t            out_inst1_o,
    output fetch_pkg::issue_t           out_issue_o
);
    import fetch_pkg::*;

    // pc_gen to inst_mem.
    logic   pg_valid;
    logic   pg_ready;
    addr_t  pg_pc;
    addr_t  pg_npc;
    logic   pg_branch_flag;
    issue_t pg_issue;

    // inst_mem to if1_stage_reg.
    logic   im_valid;
    logic   im_ready;
    addr_t  im_pc;
    addr_t  im_npc;
    logic   im_branch_flag;
    issue_t im_issue;
    inst_t  im_inst0;
    inst_t  im_inst1;

    // if1_stage_reg to fetch_buffer.
    logic   s1_valid;
    logic   s1_ready;
    addr_t  s1_pc;
    addr_t  s1_npc;
    logic   s1_branch_flag;
    issue_t s1_issue;
    inst_t  s1_inst0;
    inst_t  s1_inst1;

    pc_gen u_pc_gen (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .flush_i           (redirect_valid_i),
        .redirect_pc_i     (redirect_pc_i),
        .req_valid_o       (pg_valid),
        .req_ready_i       (pg_ready),
        .req_pc_o          (pg_pc),
        .req_npc_o         (pg_npc),
        .req_branch_flag_o (pg_branch_flag),
        .req_issue_o       (pg_issue)
    );

    inst_mem #(
        .IMEM_PAIRS (IMEM_PAIRS)
    ) u_inst_mem (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .flush_i           (redirect_valid_i),
        .we_i              (imem_we_i),
        .waddr_i           (imem_waddr_i),
        .wdata_i           (imem_wdata_i),
        .req_valid_i       (pg_valid),
        .req_ready_o       (pg_ready),
        .req_pc_i          (pg_pc),
        .req_npc_i         (pg_npc),
        .req_branch_flag_i (pg_branch_flag),
        .req_issue_i       (pg_issue),
        .rsp_valid_o       (im_valid),
        .rsp_ready_i       (im_ready),
        .rsp_pc_o          (im_pc),
        .rsp_npc_o         (im_npc),
        .rsp_branch_flag_o (im_branch_flag),
        .rsp_issue_o       (im_issue),
        .rsp_inst0_o       (im_inst0),
        .rsp_inst1_o       (im_inst1)
    );

    if1_stage_reg u_if1_stage_reg (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .flush_i           (redirect_valid_i),
        .rsp_valid_i       (im_valid),
        .rsp_ready_o       (im_ready),
        .rsp_pc_i          (im_pc),
        .rsp_npc_i         (im_npc),
        .rsp_branch_flag_i (im_branch_flag),
        .rsp_issue_i       (im_issue),
        .rsp_inst0_i       (im_inst0),
        .rsp_inst1_i       (im_inst1),
        .s_valid_o         (s1_valid),
        .s_ready_i         (s1_ready),
        .pc_o              (s1_pc),
        .npc_o             (s1_npc),
        .branch_flag_o     (s1_branch_flag),
        .inst0_o           (s1_inst0),
        .inst1_o           (s1_inst1),
        .issue_o           (s1_issue)
    );

    fetch_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fetch_buffer (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .flush_i           (redirect_valid_i),
        .in_valid_i        (s1_valid),
        .in_ready_o        (s1_ready),
        .in_pc_i           (s1_pc),
        .in_npc_i          (s1_npc),
        .in_branch_flag_i  (s1_branch_flag),
        .in_inst0_i        (s1_inst0),
        .in_inst1_i        (s1_inst1),
        .in_issue_i        (s1_issue),
        .out_valid_o       (out_valid_o),
        .out_ready_i       (out_ready_i),
        .out_pc_o          (out_pc_o),
        .out_npc_o         (out_npc_o),
        .out_branch_flag_o (out_branch_flag_o),
        .out_inst0_o       (out_inst0_o),
        .out_inst1_o       (out_inst1_o),
        .out_issue_o       (out_issue_o)
    );

endmodule

// ==== testbench/fetch_properties.sv ====
`timescale 1ns/1ps

module fetch_properties (
    input logic              aclk,
    input logic              aresetn,
    input logic              flush_i,
    input logic              im_valid_i,
    input logic              s1_valid_i,
    input logic              out_valid_i,
    input logic              out_ready_i,
    input fetch_pkg::addr_t  out_pc_i,
    input fetch_pkg::addr_t  out_npc_i,
    input logic              out_branch_flag_i,
    input fetch_pkg::inst_t  out_inst0_i,
    input fetch_pkg::inst_t  out_inst1_i,
    input fetch_pkg::issue_t out_issue_i
);

    int fail_count = 0;  // Number of assertion failures so far.

    // A waiting pair may only leave through a transfer or a flush.
    property out_held_until_ready;
        @(posedge aclk) disable iff (!aresetn)
        (out_valid_i && !out_ready_i && !flush_i) |=>
            (out_valid_i && $stable({out_pc_i, out_npc_i, out_branch_flag_i,
                                     out_inst0_i, out_inst1_i, out_issue_i}));
    endproperty

    property flush_clears_valids;
        @(posedge aclk) disable iff (!aresetn)
        flush_i |=> (!im_valid_i && !s1_valid_i && !out_valid_i);
    endproperty

    property reset_clears_output;
        @(posedge aclk) !aresetn |=> !out_valid_i;
    endproperty

    a_out_held: assert property (out_held_until_ready)
        else begin
            fail_count++;
            $error("Output pair changed or vanished before it was taken.");
        end
    a_flush: assert property (flush_clears_valids)
        else begin
            fail_count++;
            $error("A stage still holds a valid pair after a flush.");
        end
    a_reset: assert property (reset_clears_output)
        else begin
            fail_count++;
            $error("Output valid is high after reset.");
        end

endmodule

bind fetch_top fetch_properties u_fetch_properties (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .flush_i           (redirect_valid_i),
    .im_valid_i        (im_valid),
    .s1_valid_i        (s1_valid),
    .out_valid_i       (out_valid_o),
    .out_ready_i       (out_ready_i),
    .out_pc_i          (out_pc_o),
    .out_npc_i         (out_npc_o),
    .out_branch_flag_i (out_branch_flag_o),
    .out_inst0_i       (out_inst0_o),
    .out_inst1_i       (out_inst1_o),
    .out_issue_i       (out_issue_o)
);

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int IMEM_PAIRS = 64;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int WADDR_W = $clog2(IMEM_PAIRS) + 1;
    localparam int TOTAL_PAIRS = 72;  // Sum of the pairs taken over all tests.
    localparam int TIMEOUT_CYCLES = 2 * IMEM_PAIRS + RESET_CYCLES + 25 * TOTAL_PAIRS;

    typedef struct packed {
        addr_t  pc;
        addr_t  npc;
        logic   branch_flag;
        inst_t  inst0;
        inst_t  inst1;
        issue_t issue;
    } pair_t;

    logic               aclk = 1'b0;
    logic               aresetn;
    logic               redirect_valid_i;
    addr_t              redirect_pc_i;
    logic               imem_we_i;
    logic [WADDR_W-1:0] imem_waddr_i;
    inst_t              imem_wdata_i;
    logic               out_valid_o;
    logic               out_ready_i;
    addr_t              out_pc_o;
    addr_t              out_npc_o;
    logic               out_branch_flag_o;
    inst_t              out_inst0_o;
    inst_t              out_inst1_o;
    issue_t             out_issue_o;

    inst_t  mem_copy [2 * IMEM_PAIRS];
    pair_t  exp_q [$];
    addr_t  exp_addr;
    logic   exp_first;
    int     rcv_count = 0;
    int     error_count = 0;
    integer seed = 23;
    integer rnd;
    string  test_name = "idle";

    fetch_top #(
        .IMEM_PAIRS (IMEM_PAIRS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .redirect_valid_i  (redirect_valid_i),
        .redirect_pc_i     (redirect_pc_i),
        .imem_we_i         (imem_we_i),
        .imem_waddr_i      (imem_waddr_i),
        .imem_wdata_i      (imem_wdata_i),
        .out_valid_o       (out_valid_o),
        .out_ready_i       (out_ready_i),
        .out_pc_o          (out_pc_o),
        .out_npc_o         (out_npc_o),
        .out_branch_flag_o (out_branch_flag_o),
        .out_inst0_o       (out_inst0_o),
        .out_inst1_o       (out_inst1_o),
        .out_issue_o       (out_issue_o)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic pair_t ref_pair(input addr_t addr, input logic redirect,
                                       input inst_t img [2 * IMEM_PAIRS]);
        pair_t       p;
        addr_t       base;
        int unsigned idx;
        base = {addr[31:3], 3'b000};
        idx = (base >> 3) % IMEM_PAIRS;  // Memory wraps every IMEM_PAIRS pairs.
        p.pc = addr;
        p.npc = base + 32'd8;
        p.branch_flag = redirect;
        p.inst0 = img[2 * idx];
        p.inst1 = img[2 * idx + 1];
        p.issue = addr[2] ? 2'b10 : 2'b11;
        return p;
    endfunction

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic restart_model(input addr_t start, input logic redirect);
        exp_q.delete();
        exp_addr = start;
        exp_first = redirect;
    endtask

    task automatic expect_pairs(input int n);
        pair_t p;
        for (int i = 0; i < n; i++) begin
            p = ref_pair(exp_addr, exp_first, mem_copy);
            exp_q.push_back(p);
            exp_addr = p.npc;
            exp_first = 1'b0;
        end
    endtask

    task automatic load_memory();
        for (int w = 0; w < 2 * IMEM_PAIRS; w++) begin
            rnd = $random(seed);
            mem_copy[w] = inst_t'(rnd);
            imem_we_i = 1'b1;
            imem_waddr_i = WADDR_W'(w);
            imem_wdata_i = inst_t'(rnd);
            @(negedge aclk);
        end
        imem_we_i = 1'b0;
    endtask

    // Takes n pairs from the DUT and leaves out_ready_i low afterwards.
    task automatic run_pairs(input int n, input logic random_ready);
        int target;
        target = rcv_count + n;
        expect_pairs(n);
        while (rcv_count < target) begin
            if (random_ready) begin
                rnd = $random(seed);
                out_ready_i = rnd[0];
            end else begin
                out_ready_i = 1'b1;
            end
            @(negedge aclk);
        end
        out_ready_i = 1'b0;
    endtask

    task automatic redirect_to(input addr_t target);
        out_ready_i = 1'b0;  // No pair leaves on the flush edge.
        redirect_valid_i = 1'b1;
        redirect_pc_i = target;
        restart_model(target, 1'b1);
        @(negedge aclk);
        redirect_valid_i = 1'b0;
    endtask

    always @(posedge aclk) begin : compare_outputs
        pair_t exp_pair;
        if (aresetn && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                stop_on_error($sformatf("%s: a pair at pc %h arrived with none expected",
                                        test_name, out_pc_o));
            end else begin
                exp_pair = exp_q.pop_front();
                check($sformatf("%s pc", test_name), exp_pair.pc, out_pc_o);
                check($sformatf("%s npc", test_name), exp_pair.npc, out_npc_o);
                check($sformatf("%s branch_flag", test_name), 32'(exp_pair.branch_flag),
                      32'(out_branch_flag_o));
                check($sformatf("%s inst0", test_name), exp_pair.inst0, out_inst0_o);
                check($sformatf("%s inst1", test_name), exp_pair.inst1, out_inst1_o);
                check($sformatf("%s issue", test_name), 32'(exp_pair.issue), 32'(out_issue_o));
                rcv_count++;
            end
        end
    end

    always @(UUT.u_fetch_properties.fail_count) begin
        if (UUT.u_fetch_properties.fail_count != 0) begin
            stop_on_error($sformatf("A bound assertion failed during test %s.", test_name));
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        stop_on_error($sformatf("Watchdog ran out after %0d cycles during test %s.",
                                TIMEOUT_CYCLES, test_name));
    end

    initial begin
        aresetn = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        imem_we_i = 1'b0;
        imem_waddr_i = '0;
        imem_wdata_i = '0;
        out_ready_i = 1'b0;
        @(negedge aclk);
        load_memory();  // The program goes in while the DUT is held in reset.
        repeat (RESET_CYCLES) @(negedge aclk);
        aresetn = 1'b1;

        test_name = "reset_stream";
        restart_model(`INIT_ADDR, 1'b0);
        run_pairs(12, 1'b0);

        test_name = "odd_redirect";
        redirect_to(32'h0000_0054);
        run_pairs(8, 1'b0);

        test_name = "random_ready";
        run_pairs(40, 1'b1);

        test_name = "flush_full";
        while (UUT.s1_ready) begin
            @(negedge aclk);  // With out_ready_i low this waits for a full buffer.
        end
        redirect_to(32'h0000_00a0);
        run_pairs(6, 1'b1);

        test_name = "wrap";
        redirect_to(addr_t'((IMEM_PAIRS - 1) * 8));
        run_pairs(6, 1'b0);

        if (error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/inst_mem.sv
hdl/if1_stage_reg.sv
hdl/fetch_buffer.sv
hdl/fetch_top.sv
testbench/fetch_properties.sv
testbench/fetch_tb.sv
